// File: src/isq_pkg.sv
// issue queue shared definitions
// queue sizes, instruction word layout and per-line state bits
`default_nettype none

package isq_pkg;

   //////////////////////////////////////////////////////////////////////
   // queue sizing
   //////////////////////////////////////////////////////////////////////

   // number of queue lines
   localparam int ISQ_DEPTH = 8;
   // bits needed to name one line
   localparam int ISQ_IDX_W = 3;
   // dispatch ports per cycle
   localparam int INST_PORT = 2;
   // full register tag width on the wakeup bus
   localparam int TAG_W = 4;
   // low tag bits kept in the instruction for matching
   localparam int SRC_TAG_W = 3;

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////

   // instruction word, 16 bits, msb first
   typedef struct packed {
      // opaque payload
      logic [6:0]           op;
      // dispatched behind an unresolved branch
      logic                 spec;
      // operand not produced yet
      logic                 src_pend;
      // low tag bits of the producer
      logic [SRC_TAG_W-1:0] src_tag;
      logic [TAG_W-1:0]     dst_tag;
   } inst_t;

   // control bits held per line
   typedef struct packed {
      logic valid;
      // waiting on a source tag
      logic src_wait;
      // waiting on a branch resolve
      logic brn_wait;
   } line_state_t;

   // line number, doubles as the issue index
   typedef logic [ISQ_IDX_W-1:0] isq_idx_t;

endpackage

`default_nettype wire

// File: src/isq_ctrl_if.sv
// issue queue control bundle
// per-line write and clear strobes toward the lines, line status back out
`timescale 1ns/100ps
`default_nettype none

interface isq_ctrl_if;

   // allocator side
   logic [isq_pkg::ISQ_DEPTH-1:0] wr_en;
   // dispatch port feeding each line
   logic [isq_pkg::ISQ_DEPTH-1:0] wr_port;

   // scheduler side
   logic [isq_pkg::ISQ_DEPTH-1:0] clr_wait;
   logic [isq_pkg::ISQ_DEPTH-1:0] clr_brn_wait;
   logic [isq_pkg::ISQ_DEPTH-1:0] flush;
   logic [isq_pkg::ISQ_DEPTH-1:0] issue_clr;

   // line contents, array position is the line index
   isq_pkg::line_state_t state [isq_pkg::ISQ_DEPTH];
   isq_pkg::inst_t       inst  [isq_pkg::ISQ_DEPTH];

   modport alloc (output wr_en, wr_port, input state);
   modport sched (output clr_wait, clr_brn_wait, flush, issue_clr, input state, inst);
   modport queue (input wr_en, wr_port, clr_wait, clr_brn_wait, flush, issue_clr,
                  output state, inst);

endinterface

`default_nettype wire

// File: src/isq_line.sv
// issue queue line
// holds one instruction and its valid, wait and branch-wait bits
`timescale 1ns/100ps
`default_nettype none

module isq_line
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire                  wr_en_i,
   input  isq_pkg::inst_t       wr_inst_i,
   input  wire                  clr_wait_i,
   input  wire                  clr_brn_wait_i,
   input  wire                  flush_i,
   input  wire                  issue_clr_i,
   output isq_pkg::line_state_t state_o,
   output isq_pkg::inst_t       inst_o
);

   isq_pkg::line_state_t state_q;
   isq_pkg::inst_t       inst_q;

   // state bits
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
      end
      else if (wr_en_i)
      begin
         // new entry starts with wait bits taken from the instruction
         state_q.valid    <= 1'b1;
         state_q.src_wait <= wr_inst_i.src_pend;
         state_q.brn_wait <= wr_inst_i.spec;
      end
      else
      begin
         // flush and issue both retire the line
         if (flush_i || issue_clr_i)
         begin
            state_q.valid <= 1'b0;
         end
         // operand produced
         if (clr_wait_i)
         begin
            state_q.src_wait <= 1'b0;
         end
         // branch resolved as predicted
         if (clr_brn_wait_i)
         begin
            state_q.brn_wait <= 1'b0;
         end
      end
   end

   // payload, only loaded on a write
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         inst_q <= wr_inst_i;
      end
   end

   assign state_o = state_q;
   assign inst_o  = inst_q;

endmodule

`default_nettype wire

// File: src/isq.sv
// issue queue line array
// steers each dispatch port to its chosen line and gathers all lines
// onto the control bundle, array position giving the line index
`timescale 1ns/100ps
`default_nettype none

module isq
(
   input  wire            clk,
   input  wire            rst_n,
   input  isq_pkg::inst_t dispatch_inst_i [isq_pkg::INST_PORT],
   isq_ctrl_if.queue      ctrl
);

   //////////////////////////////////////////////////////////////////////
   // port steering
   //////////////////////////////////////////////////////////////////////

   // instruction offered to each line
   isq_pkg::inst_t line_inst [isq_pkg::ISQ_DEPTH];

   for (genvar g = 0; g < isq_pkg::ISQ_DEPTH; g++)
   begin : g_steer
      // wr_port picks the dispatch port for this line
      assign line_inst[g] = dispatch_inst_i[ctrl.wr_port[g]];
   end

   //////////////////////////////////////////////////////////////////////
   // line array
   //////////////////////////////////////////////////////////////////////

   // line g is index g, nothing stored for the index itself
   for (genvar g = 0; g < isq_pkg::ISQ_DEPTH; g++)
   begin : g_line
      isq_line u_line
      (
         .clk            (clk),
         .rst_n          (rst_n),
         .wr_en_i        (ctrl.wr_en[g]),
         .wr_inst_i      (line_inst[g]),
         .clr_wait_i     (ctrl.clr_wait[g]),
         .clr_brn_wait_i (ctrl.clr_brn_wait[g]),
         .flush_i        (ctrl.flush[g]),
         .issue_clr_i    (ctrl.issue_clr[g]),
         .state_o        (ctrl.state[g]),
         .inst_o         (ctrl.inst[g])
      );
   end

endmodule

`default_nettype wire

// File: src/isq_alloc.sv
// issue queue allocator
// counts free lines for dispatch ready, maps valid ports onto the
// lowest free lines
`timescale 1ns/100ps
`default_nettype none

module isq_alloc
(
   input  wire [isq_pkg::INST_PORT-1:0] dispatch_valid_i,
   output logic                         dispatch_ready_o,
   isq_ctrl_if.alloc                    ctrl
);

   logic [isq_pkg::ISQ_DEPTH-1:0] free;
   // wide enough to hold ISQ_DEPTH
   logic [isq_pkg::ISQ_IDX_W:0]   free_cnt;
   isq_pkg::isq_idx_t             first_idx;
   isq_pkg::isq_idx_t             second_idx;
   isq_pkg::isq_idx_t             port1_idx;

   //////////////////////////////////////////////////////////////////////
   // free line search
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      free_cnt   = '0;
      first_idx  = '0;
      second_idx = '0;
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         free[i] = ~ctrl.state[i].valid;
         if (free[i])
         begin
            free_cnt = free_cnt + 1'b1;
         end
      end
      // walk downward so the lowest free line wins
      for (int i = isq_pkg::ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (free[i])
         begin
            first_idx = isq_pkg::isq_idx_t'(i);
         end
      end
      // same walk, skipping the first pick
      for (int i = isq_pkg::ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (free[i] && (isq_pkg::isq_idx_t'(i) != first_idx))
         begin
            second_idx = isq_pkg::isq_idx_t'(i);
         end
      end
   end

   // room for a full dispatch group
   assign dispatch_ready_o = (free_cnt >= 2);

   //////////////////////////////////////////////////////////////////////
   // port to line mapping
   //////////////////////////////////////////////////////////////////////

   // port 1 slides down when port 0 is idle
   assign port1_idx = dispatch_valid_i[0] ? second_idx : first_idx;

   always_comb
   begin
      ctrl.wr_en   = '0;
      ctrl.wr_port = '0;
      if (dispatch_ready_o)
      begin
         if (dispatch_valid_i[0])
         begin
            ctrl.wr_en[first_idx] = 1'b1;
         end
         if (dispatch_valid_i[1])
         begin
            ctrl.wr_en[port1_idx]   = 1'b1;
            ctrl.wr_port[port1_idx] = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/isq_sched.sv
// issue queue scheduler
// tag wakeup, branch resolve and flush strobes, and lowest-index
// selection of a ready entry for the issue port
`timescale 1ns/100ps
`default_nettype none

module isq_sched
(
   input  wire                       wake_valid_i,
   input  wire [isq_pkg::TAG_W-1:0]  wake_tag_i,
   input  wire                       brn_resolve_i,
   input  wire                       brn_mispredict_i,
   input  wire                       issue_ready_i,
   output logic                      issue_valid_o,
   output isq_pkg::inst_t            issue_inst_o,
   output isq_pkg::isq_idx_t         issue_idx_o,
   isq_ctrl_if.sched                 ctrl
);

   // lines with nothing left to wait for
   logic [isq_pkg::ISQ_DEPTH-1:0] rdy;
   isq_pkg::isq_idx_t             sel_idx;

   //////////////////////////////////////////////////////////////////////
   // wakeup and resolve
   //////////////////////////////////////////////////////////////////////

   for (genvar g = 0; g < isq_pkg::ISQ_DEPTH; g++)
   begin : g_match
      // only stored waiting entries, low tag bits compared
      assign ctrl.clr_wait[g] = wake_valid_i && ctrl.state[g].valid &&
                                ctrl.state[g].src_wait &&
                                (ctrl.inst[g].src_tag ==
                                 wake_tag_i[isq_pkg::SRC_TAG_W-1:0]);

      // correct prediction releases speculative entries
      assign ctrl.clr_brn_wait[g] = brn_resolve_i && !brn_mispredict_i &&
                                    ctrl.state[g].valid && ctrl.state[g].brn_wait;

      // misprediction kills them
      assign ctrl.flush[g] = brn_resolve_i && brn_mispredict_i &&
                             ctrl.state[g].valid && ctrl.state[g].brn_wait;

      assign rdy[g] = ctrl.state[g].valid && !ctrl.state[g].src_wait &&
                      !ctrl.state[g].brn_wait;
   end

   //////////////////////////////////////////////////////////////////////
   // issue select
   //////////////////////////////////////////////////////////////////////

   // priority encoder, lowest ready line wins
   always_comb
   begin
      sel_idx = '0;
      for (int i = isq_pkg::ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (rdy[i])
         begin
            sel_idx = isq_pkg::isq_idx_t'(i);
         end
      end
   end

   assign issue_valid_o = |rdy;
   assign issue_inst_o  = ctrl.inst[sel_idx];
   assign issue_idx_o   = sel_idx;

   // retire the offered line on handshake
   always_comb
   begin
      ctrl.issue_clr = '0;
      if (issue_valid_o && issue_ready_i)
      begin
         ctrl.issue_clr[sel_idx] = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/isq_top.sv
// issue queue top level
// allocator, line array and scheduler joined by the control bundle
`timescale 1ns/100ps
`default_nettype none

module isq_top
(
   input  wire                          clk,
   input  wire                          rst_n,
   // dispatch
   input  wire [isq_pkg::INST_PORT-1:0] dispatch_valid_i,
   input  isq_pkg::inst_t               dispatch_inst_i [isq_pkg::INST_PORT],
   output logic                         dispatch_ready_o,
   // wakeup
   input  wire                          wake_valid_i,
   input  wire [isq_pkg::TAG_W-1:0]     wake_tag_i,
   // branch resolve
   input  wire                          brn_resolve_i,
   input  wire                          brn_mispredict_i,
   // issue
   output logic                         issue_valid_o,
   output isq_pkg::inst_t               issue_inst_o,
   output isq_pkg::isq_idx_t            issue_idx_o,
   input  wire                          issue_ready_i
);

   isq_ctrl_if ctrl ();

   isq_alloc u_alloc
   (
      .dispatch_valid_i (dispatch_valid_i),
      .dispatch_ready_o (dispatch_ready_o),
      .ctrl             (ctrl.alloc)
   );

   isq u_isq
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .dispatch_inst_i (dispatch_inst_i),
      .ctrl            (ctrl.queue)
   );

   isq_sched u_sched
   (
      .wake_valid_i     (wake_valid_i),
      .wake_tag_i       (wake_tag_i),
      .brn_resolve_i    (brn_resolve_i),
      .brn_mispredict_i (brn_mispredict_i),
      .issue_ready_i    (issue_ready_i),
      .issue_valid_o    (issue_valid_o),
      .issue_inst_o     (issue_inst_o),
      .issue_idx_o      (issue_idx_o),
      .ctrl             (ctrl.sched)
   );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// testbench clock and reset
// 10 ns clock, rst_n held low for the first 5 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen
(
   output logic clk,
   output logic rst_n
);

   // free running clock
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release away from the rising edge
   initial
   begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb/isq_tb.sv
// issue queue testbench
// directed tests checked every cycle against a line-level reference model
`timescale 1ns/100ps
`default_nettype none

module isq_tb;

   // cycles any single wait may take
   localparam int TMO = 50;

   logic                          clk;
   logic                          rst_n;
   logic [isq_pkg::INST_PORT-1:0] dispatch_valid;
   isq_pkg::inst_t                dispatch_inst [isq_pkg::INST_PORT];
   logic                          dispatch_ready;
   logic                          wake_valid;
   logic [isq_pkg::TAG_W-1:0]     wake_tag;
   logic                          brn_resolve;
   logic                          brn_mispredict;
   logic                          issue_valid;
   isq_pkg::inst_t                issue_inst;
   isq_pkg::isq_idx_t             issue_idx;
   logic                          issue_ready;

   // reference model with one entry per line
   isq_pkg::line_state_t model_state [isq_pkg::ISQ_DEPTH];
   isq_pkg::inst_t       model_inst  [isq_pkg::ISQ_DEPTH];
   // instructions a test wants to see again
   isq_pkg::inst_t       held        [isq_pkg::ISQ_DEPTH];

   int          err_cnt;
   int          chk_cnt;
   string       cur_test;
   logic [31:0] rng;

   tb_clk_gen u_clk_gen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   isq_top uut
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .dispatch_valid_i (dispatch_valid),
      .dispatch_inst_i  (dispatch_inst),
      .dispatch_ready_o (dispatch_ready),
      .wake_valid_i     (wake_valid),
      .wake_tag_i       (wake_tag),
      .brn_resolve_i    (brn_resolve),
      .brn_mispredict_i (brn_mispredict),
      .issue_valid_o    (issue_valid),
      .issue_inst_o     (issue_inst),
      .issue_idx_o      (issue_idx),
      .issue_ready_i    (issue_ready)
   );

   //////////////////////////////////////////////////////////////////////
   // random fields and compares
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // random op and dst with control fields chosen by the test
   function automatic isq_pkg::inst_t make_inst(input logic spec, input logic pend,
                                                input logic [isq_pkg::SRC_TAG_W-1:0] tag);
      isq_pkg::inst_t r;
      rng        = xorshift(rng);
      r.op       = rng[6:0];
      r.spec     = spec;
      r.src_pend = pend;
      r.src_tag  = tag;
      r.dst_tag  = rng[11:8];
      return r;
   endfunction

   task automatic check_inst(input string name, input isq_pkg::inst_t exp,
                             input isq_pkg::inst_t act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("FAIL %s: expected inst %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_idx(input string name, input isq_pkg::isq_idx_t exp,
                            input isq_pkg::isq_idx_t act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("FAIL %s: expected idx %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("FAIL %s: expected %b actual %b", name, exp, act);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic int model_free();
      int n;
      n = 0;
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         if (!model_state[i].valid)
         begin
            n++;
         end
      end
      return n;
   endfunction

   // lowest free line other than skip or -1 if none
   function automatic int model_lowest_free(input int skip);
      int r;
      r = -1;
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         if (r < 0 && !model_state[i].valid && i != skip)
         begin
            r = i;
         end
      end
      return r;
   endfunction

   // lowest line with nothing to wait for or -1 if none
   function automatic int model_sel();
      int r;
      r = -1;
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         if (r < 0 && model_state[i].valid && !model_state[i].src_wait &&
             !model_state[i].brn_wait)
         begin
            r = i;
         end
      end
      return r;
   endfunction

   task automatic model_load(input int line, input isq_pkg::inst_t inst);
      model_state[line].valid    = 1'b1;
      model_state[line].src_wait = inst.src_pend;
      model_state[line].brn_wait = inst.spec;
      model_inst[line]           = inst;
   endtask

   // outputs against the model at the falling edge
   task automatic compare_outputs();
      int sel;
      sel = model_sel();
      check_flag({cur_test, " dispatch_ready"}, model_free() >= 2, dispatch_ready);
      check_flag({cur_test, " issue_valid"}, sel >= 0, issue_valid);
      if (sel >= 0 && issue_valid)
      begin
         check_idx(cur_test, isq_pkg::isq_idx_t'(sel), issue_idx);
         check_inst(cur_test, model_inst[sel], issue_inst);
      end
   endtask

   // one clock with the inputs as driven and the model stepped alongside
   task automatic tick();
      isq_pkg::line_state_t nxt [isq_pkg::ISQ_DEPTH];
      int   sel;
      int   l0;
      int   l1;
      logic accept;
      sel    = model_sel();
      accept = (model_free() >= 2);
      l0     = model_lowest_free(-1);
      // port 1 takes the lowest line when port 0 is idle
      l1     = dispatch_valid[0] ? model_lowest_free(l0) : l0;
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         nxt[i] = model_state[i];
         if (model_state[i].valid)
         begin
            if (wake_valid && model_state[i].src_wait &&
                model_inst[i].src_tag == wake_tag[isq_pkg::SRC_TAG_W-1:0])
            begin
               nxt[i].src_wait = 1'b0;
            end
            if (brn_resolve && model_state[i].brn_wait)
            begin
               if (brn_mispredict)
               begin
                  nxt[i].valid = 1'b0;
               end
               else
               begin
                  nxt[i].brn_wait = 1'b0;
               end
            end
         end
      end
      if (issue_ready && sel >= 0)
      begin
         nxt[sel].valid = 1'b0;
      end
      @(posedge clk);
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         model_state[i] = nxt[i];
      end
      // new entries ignore same-cycle wakeup and resolve
      if (accept && dispatch_valid[0])
      begin
         model_load(l0, dispatch_inst[0]);
      end
      if (accept && dispatch_valid[1])
      begin
         model_load(l1, dispatch_inst[1]);
      end
      @(negedge clk);
      compare_outputs();
   endtask

   //////////////////////////////////////////////////////////////////////
   // drive helpers
   //////////////////////////////////////////////////////////////////////

   task automatic wait_dispatch_ready();
      int n;
      n = 0;
      while (!dispatch_ready && n < TMO)
      begin
         tick();
         n++;
      end
      if (!dispatch_ready)
      begin
         err_cnt++;
         $display("%s: dispatch never became ready within %0d cycles", cur_test, TMO);
      end
   endtask

   task automatic wait_issue_valid();
      int n;
      n = 0;
      while (!issue_valid && n < TMO)
      begin
         tick();
         n++;
      end
      if (!issue_valid)
      begin
         err_cnt++;
         $display("%s: no instruction offered on issue within %0d cycles", cur_test, TMO);
      end
   endtask

   task automatic dispatch_pair(input logic [1:0] valid, input isq_pkg::inst_t i0,
                                input isq_pkg::inst_t i1);
      dispatch_valid   = valid;
      dispatch_inst[0] = i0;
      dispatch_inst[1] = i1;
      wait_dispatch_ready();
      tick();
      dispatch_valid = '0;
   endtask

   // take the offered entry after checking it
   task automatic issue_expect(input isq_pkg::inst_t exp_inst, input int exp_idx);
      wait_issue_valid();
      check_inst(cur_test, exp_inst, issue_inst);
      check_idx(cur_test, isq_pkg::isq_idx_t'(exp_idx), issue_idx);
      issue_ready = 1'b1;
      tick();
      issue_ready = 1'b0;
   endtask

   task automatic wake(input logic [isq_pkg::TAG_W-1:0] tag);
      wake_valid = 1'b1;
      wake_tag   = tag;
      tick();
      wake_valid = 1'b0;
   endtask

   task automatic resolve(input logic mispredict);
      brn_resolve    = 1'b1;
      brn_mispredict = mispredict;
      tick();
      brn_resolve    = 1'b0;
      brn_mispredict = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset_idle();
      cur_test = "test_reset_idle";
      check_flag(cur_test, 1'b0, issue_valid);
      check_flag(cur_test, 1'b1, dispatch_ready);
      tick();
   endtask

   task automatic test_dispatch_issue();
      cur_test = "test_dispatch_issue";
      held[0] = make_inst(1'b0, 1'b0, '0);
      held[1] = make_inst(1'b0, 1'b0, '0);
      held[2] = make_inst(1'b0, 1'b0, '0);
      // both ports in one cycle into lines 0 and 1
      dispatch_pair(2'b11, held[0], held[1]);
      issue_expect(held[0], 0);
      // port 1 alone refills freed line 0
      dispatch_pair(2'b10, held[1], held[2]);
      issue_expect(held[2], 0);
      issue_expect(held[1], 1);
   endtask

   task automatic test_full_backpressure();
      isq_pkg::inst_t extra;
      cur_test = "test_full_backpressure";
      extra = make_inst(1'b0, 1'b0, '0);
      for (int i = 0; i < 7; i++)
      begin
         held[i] = make_inst(1'b0, 1'b1, 3'd7);
      end
      dispatch_pair(2'b11, held[0], held[1]);
      dispatch_pair(2'b11, held[2], held[3]);
      dispatch_pair(2'b11, held[4], held[5]);
      dispatch_pair(2'b10, extra, held[6]);
      // one line left is below a full group
      check_flag(cur_test, 1'b0, dispatch_ready);
      // ready entries held on the ports must not land in line 7
      dispatch_valid   = 2'b11;
      dispatch_inst[0] = extra;
      dispatch_inst[1] = make_inst(1'b0, 1'b0, '0);
      repeat (3) tick();
      dispatch_valid = '0;
      check_flag(cur_test, 1'b0, issue_valid);
      // tag 15 matches src_tag 7 through its low bits
      wake(4'hf);
      wait_issue_valid();
      repeat (4)
      begin
         check_idx(cur_test, '0, issue_idx);
         check_inst(cur_test, held[0], issue_inst);
         tick();
      end
      for (int i = 0; i < 7; i++)
      begin
         issue_expect(held[i], i);
      end
   endtask

   task automatic test_wakeup();
      logic [isq_pkg::SRC_TAG_W-1:0] tags [6];
      cur_test = "test_wakeup";
      tags = '{3'd1, 3'd2, 3'd1, 3'd3, 3'd1, 3'd2};
      for (int i = 0; i < 6; i++)
      begin
         held[i] = make_inst(1'b0, 1'b1, tags[i]);
      end
      dispatch_pair(2'b11, held[0], held[1]);
      dispatch_pair(2'b11, held[2], held[3]);
      dispatch_pair(2'b11, held[4], held[5]);
      check_flag(cur_test, 1'b0, issue_valid);
      // tag 9 has low bits 1
      wake(4'h9);
      issue_expect(held[0], 0);
      issue_expect(held[2], 2);
      issue_expect(held[4], 4);
      check_flag(cur_test, 1'b0, issue_valid);
      // release the rest
      wake(4'h2);
      wake(4'hb);
      issue_expect(held[1], 1);
      issue_expect(held[3], 3);
      issue_expect(held[5], 5);
   endtask

   task automatic test_branch_resolve();
      cur_test = "test_branch_resolve";
      held[0] = make_inst(1'b1, 1'b0, '0);
      held[1] = make_inst(1'b1, 1'b0, '0);
      dispatch_pair(2'b11, held[0], held[1]);
      check_flag(cur_test, 1'b0, issue_valid);
      resolve(1'b0);
      issue_expect(held[0], 0);
      issue_expect(held[1], 1);
      // spec on port 0 and plain on port 1
      held[2] = make_inst(1'b1, 1'b0, '0);
      held[3] = make_inst(1'b0, 1'b0, '0);
      held[4] = make_inst(1'b1, 1'b0, '0);
      held[5] = make_inst(1'b0, 1'b0, '0);
      dispatch_pair(2'b11, held[2], held[3]);
      dispatch_pair(2'b11, held[4], held[5]);
      resolve(1'b1);
      // only the survivors in lines 1 and 3
      issue_expect(held[3], 1);
      issue_expect(held[5], 3);
      check_flag(cur_test, 1'b0, issue_valid);
      check_flag(cur_test, 1'b1, dispatch_ready);
      // flushed line 0 is free again and taken first
      held[6] = make_inst(1'b0, 1'b0, '0);
      dispatch_pair(2'b01, held[6], held[6]);
      issue_expect(held[6], 0);
      check_flag(cur_test, 1'b0, issue_valid);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin : main
      int n;
      dispatch_valid   = '0;
      dispatch_inst[0] = '0;
      dispatch_inst[1] = '0;
      wake_valid       = 1'b0;
      wake_tag         = '0;
      brn_resolve      = 1'b0;
      brn_mispredict   = 1'b0;
      issue_ready      = 1'b0;
      err_cnt          = 0;
      chk_cnt          = 0;
      rng              = 32'd44305;
      cur_test         = "reset";
      for (int i = 0; i < isq_pkg::ISQ_DEPTH; i++)
      begin
         model_state[i] = '0;
         model_inst[i]  = '0;
      end
      n = 0;
      while (rst_n !== 1'b1 && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (rst_n !== 1'b1)
      begin
         err_cnt++;
         $display("reset was never released within %0d cycles", TMO);
      end
      @(negedge clk);
      test_reset_idle();
      test_dispatch_issue();
      test_full_backpressure();
      test_wakeup();
      test_branch_resolve();
      $display("checks %0d errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: isq.f
src/isq_pkg.sv
src/isq_ctrl_if.sv
src/isq_line.sv
src/isq.sv
src/isq_alloc.sv
src/isq_sched.sv
src/isq_top.sv
tb/tb_clk_gen.sv
tb/isq_tb.sv

// File: Bender.yml
package:
  name: isq

sources:
  - src/isq_pkg.sv
  - src/isq_ctrl_if.sv
  - src/isq_line.sv
  - src/isq.sv
  - src/isq_alloc.sv
  - src/isq_sched.sv
  - src/isq_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/isq_tb.sv
